//--- hw/field_painter.sv
`default_nettype none
`include "obstacle_settings.svh"

module field_painter (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::rgb_t   rgb_in,
    input  logic                 active,
    hole_if.view                 hole,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y
);

    localparam obstacle_pkg::coord_t TOP    = 12'(`FIELD_TOP);
    localparam obstacle_pkg::coord_t BOTTOM = 12'(`FIELD_BOTTOM);
    localparam obstacle_pkg::coord_t LEFT   = 12'(`FIELD_LEFT);
    localparam obstacle_pkg::coord_t RIGHT  = 12'(`FIELD_RIGHT);
    localparam obstacle_pkg::rgb_t   RING   = 12'(`RING_RGB);

    logic in_field;
    logic on_ring;
    logic paint;

    assign in_field = (hcount >= LEFT) && (hcount <= RIGHT) &&
                      (vcount >= TOP) && (vcount <= BOTTOM);

    // outside the hole, edges themselves included
    assign on_ring = (vcount <= hole.hole_top) || (vcount >= hole.hole_bottom) ||
                     (hcount <= hole.hole_left) || (hcount >= hole.hole_right);

    assign paint = active && in_field && on_ring;

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else begin
            rgb_out    <= paint ? RING : rgb_in;
            obstacle_x <= paint ? hcount : '0;    // zero means no obstacle here
            obstacle_y <= paint ? vcount : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/hole_edges.sv
`default_nettype none
`include "obstacle_settings.svh"

module hole_edges (
    input  logic clk,
    input  logic rst,
    hole_if.edges hole
);

    localparam obstacle_pkg::coord_t TOP    = 12'(`FIELD_TOP);
    localparam obstacle_pkg::coord_t BOTTOM = 12'(`FIELD_BOTTOM);
    localparam obstacle_pkg::coord_t LEFT   = 12'(`FIELD_LEFT);
    localparam obstacle_pkg::coord_t RIGHT  = 12'(`FIELD_RIGHT);

    // one edge, one step
    function automatic obstacle_pkg::coord_t moved(
        input obstacle_pkg::coord_t     pos,
        input obstacle_pkg::edge_move_t mv
    );
        case (mv)
            obstacle_pkg::EDGE_INC: return pos + 12'd1;
            obstacle_pkg::EDGE_DEC: return pos - 12'd1;
            default:                return pos;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            hole.hole_top    <= '0;
            hole.hole_bottom <= '0;
            hole.hole_left   <= '0;
            hole.hole_right  <= '0;
        end else if (hole.load) begin   // one pixel inside the field
            hole.hole_top    <= TOP + 12'd1;
            hole.hole_bottom <= BOTTOM - 12'd1;
            hole.hole_left   <= LEFT + 12'd1;
            hole.hole_right  <= RIGHT - 12'd1;
        end else if (hole.step) begin
            hole.hole_top    <= moved(hole.hole_top, hole.top_move);
            hole.hole_bottom <= moved(hole.hole_bottom, hole.bottom_move);
            hole.hole_left   <= moved(hole.hole_left, hole.left_move);
            hole.hole_right  <= moved(hole.hole_right, hole.right_move);
        end
    end

    // the end conditions must stop every edge at the field border
    a_edges_in_field: assert property (@(posedge clk) disable iff (rst)
        (hole.load || hole.step) |=>
            (hole.hole_top    >= TOP  && hole.hole_top    <= BOTTOM &&
             hole.hole_bottom >= TOP  && hole.hole_bottom <= BOTTOM &&
             hole.hole_left   >= LEFT && hole.hole_left   <= RIGHT  &&
             hole.hole_right  >= LEFT && hole.hole_right  <= RIGHT));

endmodule

`default_nettype wire

//--- hw/hole_if.sv
`default_nettype none

interface hole_if;

    obstacle_pkg::coord_t hole_top;
    obstacle_pkg::coord_t hole_bottom;
    obstacle_pkg::coord_t hole_left;
    obstacle_pkg::coord_t hole_right;

    logic load;     // reset hole to the shrunk field
    logic step;     // apply the four moves once
    obstacle_pkg::edge_move_t top_move;
    obstacle_pkg::edge_move_t bottom_move;
    obstacle_pkg::edge_move_t left_move;
    obstacle_pkg::edge_move_t right_move;

    modport edges (
        output hole_top, hole_bottom, hole_left, hole_right,
        input  load, step, top_move, bottom_move, left_move, right_move
    );

    modport ctrl (
        output load, step, top_move, bottom_move, left_move, right_move,
        input  hole_top, hole_bottom, hole_left, hole_right
    );

    modport view (input hole_top, hole_bottom, hole_left, hole_right);

endinterface

`default_nettype wire

//--- hw/obstacle_pkg.sv
`default_nettype none

package obstacle_pkg;

    ////////////////////////////////////////////////////////////////////////
    // vector types

    typedef logic [11:0] coord_t;   // screen pixel position
    typedef logic [11:0] rgb_t;     // 4 bits per channel
    typedef logic [25:0] tick_t;    // step and hold timers

    ////////////////////////////////////////////////////////////////////////
    // animation phases, in the order they run

    typedef enum logic [2:0] {
        PH_IDLE          = 3'd0,
        PH_CLOSE_IN      = 3'd1,
        PH_RIGHT_TOP     = 3'd2,
        PH_RIGHT_BOTTOM  = 3'd3,
        PH_LEFT_TOP      = 3'd4,
        PH_CLOSE_IN_MORE = 3'd5,
        PH_LEFT_MIDDLE   = 3'd6,
        PH_CENTER        = 3'd7
    } phase_t;

    // what one hole edge does on a step
    typedef enum logic [1:0] {
        EDGE_HOLD = 2'd0,
        EDGE_INC  = 2'd1,   // down or right
        EDGE_DEC  = 2'd2    // up or left
    } edge_move_t;

endpackage

`default_nettype wire

//--- hw/phase_fsm.sv
`default_nettype none
`include "obstacle_settings.svh"

module phase_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 menu_on,
    input  logic                 play_selected,
    input  logic [3:0]           selected,
    input  logic                 done_in,
    input  logic                 step_tick,
    input  logic                 hold_done,
    hole_if.ctrl                 hole,
    output obstacle_pkg::phase_t phase,
    output logic                 at_end,
    output logic                 fast,
    output logic                 done
);

    localparam logic [3:0] GAME = 4'(`GAME_CODE);

    // end thresholds of the phases
    localparam obstacle_pkg::coord_t CLOSE_IN_END = 12'(`FIELD_TOP + `CLOSE_IN_DEPTH);
    localparam obstacle_pkg::coord_t RIGHT_END    = 12'(`FIELD_RIGHT);
    localparam obstacle_pkg::coord_t BOTTOM_END   = 12'(`FIELD_BOTTOM);
    localparam obstacle_pkg::coord_t TOP_END      = 12'(`FIELD_TOP);
    localparam obstacle_pkg::coord_t MORE_END     = 12'(`FIELD_LEFT + `CLOSE_MORE_RIGHT);
    localparam obstacle_pkg::coord_t MIDDLE_END   = 12'(`FIELD_TOP + `MIDDLE_DEPTH);
    localparam obstacle_pkg::coord_t CENTER_END   = 12'(`FIELD_LEFT + `CENTER_DEPTH);

    obstacle_pkg::phase_t phase_nxt;
    logic                 done_nxt;
    logic                 abort;

    assign abort     = menu_on || !play_selected;
    assign hole.load = (phase == obstacle_pkg::PH_IDLE) && done_in;
    assign hole.step = step_tick && (phase != obstacle_pkg::PH_IDLE);

    //////////////////////////////////////////////////////////////////////
    // phase table: moves as top, bottom, left, right

    always_comb begin
        hole.top_move    = obstacle_pkg::EDGE_HOLD;
        hole.bottom_move = obstacle_pkg::EDGE_HOLD;
        hole.left_move   = obstacle_pkg::EDGE_HOLD;
        hole.right_move  = obstacle_pkg::EDGE_HOLD;
        fast   = 1'b0;
        at_end = 1'b0;
        case (phase)
            obstacle_pkg::PH_CLOSE_IN: begin   // shrink from all sides
                hole.top_move    = obstacle_pkg::EDGE_INC;
                hole.bottom_move = obstacle_pkg::EDGE_DEC;
                hole.left_move   = obstacle_pkg::EDGE_INC;
                hole.right_move  = obstacle_pkg::EDGE_DEC;
                at_end = hole.hole_top >= CLOSE_IN_END;
            end
            obstacle_pkg::PH_RIGHT_TOP: begin
                hole.top_move    = obstacle_pkg::EDGE_DEC;
                hole.bottom_move = obstacle_pkg::EDGE_DEC;
                hole.left_move   = obstacle_pkg::EDGE_INC;
                hole.right_move  = obstacle_pkg::EDGE_INC;
                at_end = hole.hole_right >= RIGHT_END;
            end
            obstacle_pkg::PH_RIGHT_BOTTOM: begin
                hole.top_move    = obstacle_pkg::EDGE_INC;
                hole.bottom_move = obstacle_pkg::EDGE_INC;
                at_end = hole.hole_bottom >= BOTTOM_END;
            end
            obstacle_pkg::PH_LEFT_TOP: begin   // diagonal sweep, fast
                hole.top_move    = obstacle_pkg::EDGE_DEC;
                hole.bottom_move = obstacle_pkg::EDGE_DEC;
                hole.left_move   = obstacle_pkg::EDGE_DEC;
                hole.right_move  = obstacle_pkg::EDGE_DEC;
                fast   = 1'b1;
                at_end = hole.hole_top <= TOP_END;
            end
            obstacle_pkg::PH_CLOSE_IN_MORE: begin
                hole.bottom_move = obstacle_pkg::EDGE_DEC;
                hole.right_move  = obstacle_pkg::EDGE_DEC;
                at_end = hole.hole_right <= MORE_END;
            end
            obstacle_pkg::PH_LEFT_MIDDLE: begin
                hole.top_move    = obstacle_pkg::EDGE_INC;
                hole.bottom_move = obstacle_pkg::EDGE_INC;
                fast   = 1'b1;
                at_end = hole.hole_top >= MIDDLE_END;
            end
            obstacle_pkg::PH_CENTER: begin
                hole.left_move   = obstacle_pkg::EDGE_INC;
                hole.right_move  = obstacle_pkg::EDGE_INC;
                fast   = 1'b1;
                at_end = hole.hole_left >= CENTER_END;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // next phase

    always_comb begin
        phase_nxt = phase;
        done_nxt  = 1'b0;
        if (phase == obstacle_pkg::PH_IDLE) begin
            if (done_in && (selected == GAME) && play_selected)
                phase_nxt = obstacle_pkg::PH_CLOSE_IN;
        end else if (abort) begin
            phase_nxt = obstacle_pkg::PH_IDLE;
        end else if (hold_done) begin
            if (phase == obstacle_pkg::PH_CENTER) begin
                phase_nxt = obstacle_pkg::PH_IDLE;  // last phase finished
                done_nxt  = 1'b1;
            end else begin
                phase_nxt = obstacle_pkg::phase_t'(phase + 3'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= obstacle_pkg::PH_IDLE;
            done  <= 1'b0;
        end else begin
            phase <= phase_nxt;
            done  <= done_nxt;
        end
    end

    // a run ends once, so done is a single strobe
    a_done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

`default_nettype wire

//--- hw/phase_timer.sv
`default_nettype none
`include "obstacle_settings.svh"

module phase_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::phase_t phase,
    input  logic                 at_end,
    input  logic                 fast,
    output logic                 step_tick,
    output logic                 hold_done
);

    localparam obstacle_pkg::tick_t SLOW_PERIOD = 26'(`STEP_SLOW);
    localparam obstacle_pkg::tick_t FAST_PERIOD = 26'(`STEP_FAST);
    localparam obstacle_pkg::tick_t HOLD_PERIOD = 26'(`HOLD_CYCLES);

    obstacle_pkg::phase_t phase_q;      // phase one cycle ago
    obstacle_pkg::tick_t  step_cnt;
    obstacle_pkg::tick_t  hold_cnt;
    obstacle_pkg::tick_t  period;
    logic                 entry;        // first cycle of a new phase
    logic                 running;

    assign entry   = (phase != phase_q);
    assign running = (phase != obstacle_pkg::PH_IDLE) && !entry;
    assign period  = fast ? FAST_PERIOD : SLOW_PERIOD;

    assign step_tick = running && !at_end && (step_cnt == period);
    assign hold_done = running && at_end && (hold_cnt == HOLD_PERIOD);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q  <= obstacle_pkg::PH_IDLE;
            step_cnt <= '0;
            hold_cnt <= '0;
        end else begin
            phase_q <= phase;
            // step rate, stops once the end condition holds
            if (!running || at_end || step_tick)
                step_cnt <= '0;
            else
                step_cnt <= step_cnt + 26'd1;
            // hold counter, saturates at the period
            if (!running || !at_end)
                hold_cnt <= '0;
            else if (hold_cnt != HOLD_PERIOD)
                hold_cnt <= hold_cnt + 26'd1;
        end
    end

    a_tick_xor_hold: assert property (@(posedge clk) disable iff (rst)
        !(step_tick && hold_done));

endmodule

`default_nettype wire

//--- hw/square_follow_obstacle.sv
`default_nettype none

module square_follow_obstacle (
    input  logic                 clk,
    input  logic                 rst,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::rgb_t   rgb_in,
    input  logic                 game_on,   // not used by this game
    input  logic                 menu_on,
    input  logic                 play_selected,
    input  logic [3:0]           selected,
    input  logic                 done_in,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y,
    output logic                 done
);

    obstacle_pkg::phase_t phase;
    logic step_tick, hold_done;
    logic at_end, fast;
    logic active;

    hole_if hole_bus ();

    assign active = (phase != obstacle_pkg::PH_IDLE);

    phase_fsm phase_fsm_i (
        .clk, .rst, .menu_on, .play_selected, .selected, .done_in,
        .step_tick, .hold_done, .hole(hole_bus.ctrl),
        .phase, .at_end, .fast, .done
    );

    phase_timer phase_timer_i (.clk, .rst, .phase, .at_end, .fast, .step_tick, .hold_done);

    hole_edges hole_edges_i (.clk, .rst, .hole(hole_bus.edges));

    field_painter field_painter_i (
        .clk, .rst, .hcount, .vcount, .rgb_in, .active,
        .hole(hole_bus.view), .rgb_out, .obstacle_x, .obstacle_y
    );

endmodule

`default_nettype wire

//--- include/obstacle_settings.svh
`ifndef OBSTACLE_SETTINGS_SVH
`define OBSTACLE_SETTINGS_SVH

// game field bounds in screen pixels, all inclusive
`define FIELD_TOP        317
`define FIELD_BOTTOM     617
`define FIELD_LEFT       361
`define FIELD_RIGHT      661

// end conditions, as offsets from the field bounds
`define CLOSE_IN_DEPTH   125    // top edge, close in phase
`define CLOSE_MORE_RIGHT 40     // right edge, close in more phase
`define MIDDLE_DEPTH     130    // top edge, left middle phase
`define CENTER_DEPTH     130    // left edge, center phase

// timer periods in clock cycles
// small values for simulation, on the board these are
// 3200000, 1600000 and 32000000
`define STEP_SLOW        3
`define STEP_FAST        1
`define HOLD_CYCLES      5

// menu code of this game
`define GAME_CODE        3

// ring colour, 4:4:4
`define RING_RGB         12'hfff

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_obstacle -f tb.f -o sim_obstacle
./obj_dir/sim_obstacle | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "PASS: all tests" sim.log

//--- tb.f
+incdir+include
hw/obstacle_pkg.sv
hw/hole_if.sv
hw/phase_fsm.sv
hw/phase_timer.sv
hw/hole_edges.sv
hw/field_painter.sv
hw/square_follow_obstacle.sv
testbench/obstacle_checker.sv
testbench/tb_obstacle.sv

//--- testbench/obstacle_checker.sv
`default_nettype none

module obstacle_checker (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire obstacle_pkg::rgb_t   rgb_out,
    input  wire obstacle_pkg::coord_t obstacle_x,
    input  wire obstacle_pkg::coord_t obstacle_y,
    input  wire logic                 done,
    input  wire logic                 exp_on,     // compare the coming output
    input  wire obstacle_pkg::rgb_t   exp_rgb,
    input  wire obstacle_pkg::coord_t exp_x,
    input  wire obstacle_pkg::coord_t exp_y
);

    int errors = 0;
    int done_count = 0;

    logic                 on_q = 1'b0;
    obstacle_pkg::rgb_t   rgb_q;
    obstacle_pkg::coord_t x_q;
    obstacle_pkg::coord_t y_q;
    logic                 done_q = 1'b0;

    // expectation set up before this edge belongs to the output after it
    always @(posedge clk) begin
        on_q  <= exp_on;
        rgb_q <= exp_rgb;
        x_q   <= exp_x;
        y_q   <= exp_y;
        if (done)
            done_count <= done_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // outputs are stable at the falling edge

    always @(negedge clk) begin
        if (on_q && !rst) begin
            if (rgb_out !== rgb_q) begin
                $display("error rgb_out: got %h expected %h", rgb_out, rgb_q);
                errors = errors + 1;
            end
            if (obstacle_x !== x_q) begin
                $display("error obstacle_x: got %h expected %h", obstacle_x, x_q);
                errors = errors + 1;
            end
            if (obstacle_y !== y_q) begin
                $display("error obstacle_y: got %h expected %h", obstacle_y, y_q);
                errors = errors + 1;
            end
        end
        if (done && done_q) begin
            $display("done stayed high for more than one cycle");
            errors = errors + 1;
        end
        done_q <= done;
    end

endmodule

`default_nettype wire

//--- testbench/tb_obstacle.sv
`default_nettype none
`include "obstacle_settings.svh"

module tb_obstacle;

    logic                 clk = 1'b0;
    logic                 rst;
    obstacle_pkg::coord_t hcount, vcount, obstacle_x, obstacle_y;
    obstacle_pkg::rgb_t   rgb_in, rgb_out;
    logic                 game_on, menu_on, play_selected, done_in, done;
    logic [3:0]           selected;

    logic                 exp_on = 1'b0;
    obstacle_pkg::rgb_t   exp_rgb;
    obstacle_pkg::coord_t exp_x, exp_y;

    integer seed = 1;
    int     run_cyc = -1;   // cycle index within a run, -1 when idle
    int     gcyc = 0;
    int     total;          // cycles of a full run
    int     start_g;
    logic   loose = 1'b0;   // one pixel of slack at the hole edges
    int     tests = 0;
    int     failed = 0;
    int     fails = 0;      // checks made here in the top module

    always #20 clk = ~clk;

    square_follow_obstacle square_follow_obstacle_i (
        .clk, .rst, .hcount, .vcount, .rgb_in, .game_on, .menu_on, .play_selected,
        .selected, .done_in, .rgb_out, .obstacle_x, .obstacle_y, .done
    );

    obstacle_checker checker_i (
        .clk, .rst, .rgb_out, .obstacle_x, .obstacle_y, .done,
        .exp_on, .exp_rgb, .exp_x, .exp_y
    );

    //////////////////////////////////////////////////////////////////////
    // reference model of the phase table

    function automatic logic phase_over(input int ph, input int t, b, l, r);
        case (ph)
            1:       return t >= `FIELD_TOP + `CLOSE_IN_DEPTH;
            2:       return r >= `FIELD_RIGHT;
            3:       return b >= `FIELD_BOTTOM;
            4:       return t <= `FIELD_TOP;
            5:       return r <= `FIELD_LEFT + `CLOSE_MORE_RIGHT;
            6:       return t >= `FIELD_TOP + `MIDDLE_DEPTH;
            default: return l >= `FIELD_LEFT + `CENTER_DEPTH;
        endcase
    endfunction

    function automatic void phase_step(input int ph, inout int t, b, l, r);
        case (ph)
            1:       begin t++; b--; l++; r--; end
            2:       begin t--; b--; l++; r++; end
            3, 6:    begin t++; b++; end
            4:       begin t--; b--; l--; r--; end
            5:       begin b--; r--; end
            default: begin l++; r++; end
        endcase
    endfunction

    // length of a full run, and the hole edges seen in run cycle cyc
    function automatic int ref_run(input int cyc, output int et, eb, el, er);
        int   t, b, l, r;
        int   start, per, n, ph;
        logic got;
        t = `FIELD_TOP + 1;
        b = `FIELD_BOTTOM - 1;
        l = `FIELD_LEFT + 1;
        r = `FIELD_RIGHT - 1;
        start = 0;
        got = 1'b0;
        for (ph = 1; ph <= 7; ph++) begin
            per = (ph == 4 || ph >= 6) ? `STEP_FAST + 1 : `STEP_SLOW + 1;
            n = 0;
            while (!phase_over(ph, t, b, l, r)) begin
                n++;
                if (!got && start + n * per + 1 > cyc) begin  // step not yet visible
                    et = t; eb = b; el = l; er = r;
                    got = 1'b1;
                end
                phase_step(ph, t, b, l, r);
            end
            start = start + n * per + `HOLD_CYCLES + 2;   // steps, hold, entry, switch
        end
        if (!got) begin
            et = t; eb = b; el = l; er = r;
        end
        return start;
    endfunction

    function automatic logic in_field(input int h, v);
        return h >= `FIELD_LEFT && h <= `FIELD_RIGHT &&
               v >= `FIELD_TOP && v <= `FIELD_BOTTOM;
    endfunction

    function automatic logic ring_hit(input int h, v, t, b, l, r);
        return in_field(h, v) && (v <= t || v >= b || h <= l || h >= r);
    endfunction

    function automatic logic near_edge(input int h, v, t, b, l, r);
        return (v - t <= 1 && t - v <= 1) || (v - b <= 1 && b - v <= 1) ||
               (h - l <= 1 && l - h <= 1) || (h - r <= 1 && r - h <= 1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one clock: expectation for the inputs now driven, then new pixel

    task automatic cycle();
        int   et, eb, el, er;
        logic paint;
        void'(ref_run(run_cyc, et, eb, el, er));
        paint = run_cyc >= 0 && ring_hit(int'(hcount), int'(vcount), et, eb, el, er);
        exp_on = !rst;
        // inside the field a pixel next to a hole edge may see the edge one step off
        if (loose && run_cyc >= 0 && in_field(int'(hcount), int'(vcount)) &&
            near_edge(int'(hcount), int'(vcount), et, eb, el, er))
            exp_on = 1'b0;
        exp_rgb = paint ? `RING_RGB : rgb_in;
        exp_x = paint ? hcount : '0;
        exp_y = paint ? vcount : '0;
        if (run_cyc < 0) begin
            if (!rst && done_in && int'(selected) == `GAME_CODE && play_selected)
                run_cyc = 0;
        end else if (menu_on || !play_selected || run_cyc + 1 == total) begin
            run_cyc = -1;
        end else begin
            run_cyc++;
        end
        @(negedge clk);
        gcyc++;
        hcount = 12'(280 + {$random(seed)} % 420);
        vcount = 12'(240 + {$random(seed)} % 460);
        rgb_in = 12'($random(seed));
        done_in = 1'b0;                 // strobe lasts one cycle
    endtask

    task automatic cycles(input int n);
        for (int i = 0; i < n; i++)
            cycle();
    endtask

    task automatic start_run();
        selected = 4'(`GAME_CODE);
        play_selected = 1'b1;
        menu_on = 1'b0;
        done_in = 1'b1;
        start_g = gcyc;
        cycle();
    endtask

    // runs until the next done pulse, gives the cycles since the start
    task automatic wait_done(output int took);
        int base, n;
        base = checker_i.done_count;
        n = 0;
        while (checker_i.done_count == base && n < total + 100) begin
            cycle();
            n++;
        end
        took = gcyc - start_g;
        if (checker_i.done_count == base) begin
            $display("timeout: no done pulse within %0d cycles", n);
            fails++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = checker_i.errors + fails - errs_before;
        tests++;
        if (errs != 0)
            failed++;
        $display("test %0d %s: %s (%0d errors)", tests, name, errs == 0 ? "ok" : "bad", errs);
    endtask

    initial begin
        int d0, d1, d2, d3, took, base, e0;
        rst = 1'b1;
        hcount = '0;
        vcount = '0;
        rgb_in = '0;
        game_on = 1'b1;
        menu_on = 1'b0;
        play_selected = 1'b1;
        selected = 4'd5;
        done_in = 1'b0;
        total = ref_run(0, d0, d1, d2, d3);
        cycles(8);
        rst = 1'b0;

        e0 = checker_i.errors + fails;
        done_in = 1'b1;                 // wrong game selected
        cycles(200);
        end_test("passthrough when idle", e0);

        e0 = checker_i.errors + fails;
        start_run();
        cycles(`STEP_SLOW);
        end_test("initial ring", e0);

        e0 = checker_i.errors + fails;
        base = checker_i.done_count;
        loose = 1'b1;
        wait_done(took);
        cycles(10);
        end_test("ring during a run", e0);

        e0 = checker_i.errors + fails;
        if (checker_i.done_count != base + 1) begin
            $display("done pulsed %0d times in one run", checker_i.done_count - base);
            fails++;
        end
        if (took < total || took > total + 8) begin
            $display("done came after %0d cycles, reference says %0d", took, total);
            fails++;
        end
        end_test("done pulse", e0);

        e0 = checker_i.errors + fails;
        base = checker_i.done_count;
        start_run();
        cycles(300);
        menu_on = 1'b1;                 // abort from the menu
        cycles(total);
        menu_on = 1'b0;
        if (checker_i.done_count != base) begin
            $display("done pulsed after a menu abort");
            fails++;
        end
        end_test("menu abort", e0);

        e0 = checker_i.errors + fails;
        start_run();
        cycles(300);
        play_selected = 1'b0;
        cycles(total);
        if (checker_i.done_count != base) begin
            $display("done pulsed after play was dropped");
            fails++;
        end
        start_run();
        wait_done(took);
        cycles(10);
        if (checker_i.done_count != base + 1) begin
            $display("restart after abort did not finish with one done pulse");
            fails++;
        end
        end_test("play abort and restart", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, checker_i.errors + fails);
        if (failed == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
